/* compile.f */
+incdir+include
source/rv_decode_pkg.sv
source/rv_decoder.sv
source/issue_stage.sv
source/alu_operand_gen.sv
source/decode_issue_top.sv
tb/decode_issue_checker.sv
tb/tb_decode_issue.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode/issue testbench with Verilator

LOG=sim.log
BIN=tb_decode_issue_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_decode_issue -f compile.f -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
exit 1

/* tb/tb_decode_issue.sv */
`include "decode_issue_cfg.svh"

module tb_decode_issue;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_decode_pkg::*;

    localparam int NUM_INSTR = 400;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_INSTR = 20;
    localparam int CLK_PERIOD_NS = 100;
    localparam int DRIVE_DELAY = 2;
    localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_INSTR * CYCLES_PER_INSTR) * CLK_PERIOD_NS;

    logic clk;
    logic rst;
    logic decode_valid;
    logic [`DI_XLEN-1:0] decode_pc;
    instr_u decode_instr;
    logic decode_advance;
    logic [1:0] inuse;
    logic [1:0][4:0] rs_addr;
    logic [`DI_XLEN-1:0] rs1_data;
    logic [`DI_XLEN-1:0] rs2_data;
    logic [`DI_NUM_UNITS-1:0] unit_ready;
    logic flush;
    logic issue_hold;
    logic [`DI_NUM_UNITS-1:0] issue_to;
    logic instruction_issued;
    instr_u issue_instr;
    logic [`DI_XLEN-1:0] issue_pc;
    logic [`DI_XLEN-1:0] constant_adder;
    logic [`DI_XLEN:0] alu_in1;
    logic [`DI_XLEN:0] alu_in2;
    logic [4:0] shift_amount;
    alu_op_t alu_op;
    alu_logic_op_t alu_logic_op;
    logic alu_subtract;
    logic run_done;
    logic stage_busy;
    int value_errors;
    int protocol_errors;
    integer seed;

    decode_issue_top UUT (
        .clk (clk),
        .rst (rst),
        .decode_valid_i (decode_valid),
        .decode_pc_i (decode_pc),
        .decode_instr_i (decode_instr),
        .decode_advance_o (decode_advance),
        .inuse_i (inuse),
        .rs_addr_o (rs_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .unit_ready_i (unit_ready),
        .flush_i (flush),
        .issue_hold_i (issue_hold),
        .issue_to_o (issue_to),
        .instruction_issued_o (instruction_issued),
        .issue_instr_o (issue_instr),
        .issue_pc_o (issue_pc),
        .constant_adder_o (constant_adder),
        .alu_in1_o (alu_in1),
        .alu_in2_o (alu_in2),
        .shift_amount_o (shift_amount),
        .alu_op_o (alu_op),
        .alu_logic_op_o (alu_logic_op),
        .alu_subtract_o (alu_subtract)
    );

    decode_issue_checker u_checker (
        .clk (clk),
        .rst (rst),
        .done_i (run_done),
        .decode_valid_i (decode_valid),
        .decode_pc_i (decode_pc),
        .decode_instr_i (decode_instr),
        .decode_advance_i (decode_advance),
        .inuse_i (inuse),
        .rs_addr_i (rs_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .unit_ready_i (unit_ready),
        .flush_i (flush),
        .issue_hold_i (issue_hold),
        .issue_to_i (issue_to),
        .instruction_issued_i (instruction_issued),
        .issue_instr_i (issue_instr),
        .issue_pc_i (issue_pc),
        .constant_adder_i (constant_adder),
        .alu_in1_i (alu_in1),
        .alu_in2_i (alu_in2),
        .shift_amount_i (shift_amount),
        .alu_op_i (alu_op),
        .alu_logic_op_i (alu_logic_op),
        .alu_subtract_i (alu_subtract),
        .busy_o (stage_busy),
        .value_errors_o (value_errors),
        .protocol_errors_o (protocol_errors)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    ////////////////////////////////////////
    // Random stimulus
    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [31:0] word;
        opcode_t opc;
        int pick;
        r = $random(seed);
        word = $random(seed);
        pick = int'(r[7:0]) % 11;
        case (pick)
            0: opc = LUI;
            1: opc = AUIPC;
            2: opc = JAL;
            3: opc = JALR;
            4: opc = BRANCH;
            5: opc = LOAD;
            6: opc = STORE;
            7: opc = ARITH_IMM;
            8: opc = ARITH;
            9: opc = FENCE;
            default: opc = SYSTEM;
        endcase
        word[6:0] = {opc, 2'b11};
        // Plain, SUB/SRA and M extension encodings
        if (opc == ARITH) begin
            case (r[9:8])
                2'd0: word[31:25] = 7'b0000000;
                2'd1: word[31:25] = 7'b0100000;
                default: word[31:25] = 7'b0000001;
            endcase
        end
        return word;
    endfunction

    task automatic randomize_controls();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        unit_ready = r1[4:0] | r2[4:0];
        inuse = r1[9:8] & r2[9:8];
        issue_hold = (r1[15:13] == 3'b000);
        flush = (r2[20:16] == 5'b00000);
        rs1_data = $random(seed);
        rs2_data = $random(seed);
    endtask

    task automatic drive_instructions();
        int sent;
        logic accepted;
        logic [31:0] r;
        sent = 0;
        while (sent < NUM_INSTR) begin
            @(posedge clk);
            accepted = decode_valid && decode_advance;
            #DRIVE_DELAY;
            if (accepted) begin
                sent++;
            end
            randomize_controls();
            if (sent >= NUM_INSTR) begin
                decode_valid = 1'b0;
            end else if (accepted || !decode_valid) begin
                r = $random(seed);
                decode_valid = (r[1:0] != 2'b00);
                decode_pc = decode_pc + 32'd4;
                decode_instr = random_instr();
            end
        end
    endtask

    // Quiet controls so the last held instruction leaves
    task automatic drain_stage();
        @(posedge clk);
        #DRIVE_DELAY;
        decode_valid = 1'b0;
        unit_ready = '1;
        inuse = 2'b00;
        issue_hold = 1'b0;
        flush = 1'b0;
        while (stage_busy) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        repeat (2) @(posedge clk);
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        seed = 32'h9139;
        clk = 1'b0;
        rst = 1'b1;
        decode_valid = 1'b0;
        decode_pc = 32'h0000_1000;
        decode_instr = '0;
        inuse = 2'b00;
        rs1_data = '0;
        rs2_data = '0;
        unit_ready = '1;
        flush = 1'b0;
        issue_hold = 1'b0;
        run_done = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        drive_instructions();
        drain_stage();
        run_done = 1'b1;
        #1;
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* tb/decode_issue_checker.sv */
`include "decode_issue_cfg.svh"

module decode_issue_checker (
    input logic clk,
    input logic rst,
    input logic done_i,
    input logic decode_valid_i,
    input logic [`DI_XLEN-1:0] decode_pc_i,
    input logic [31:0] decode_instr_i,
    input logic decode_advance_i,
    input logic [1:0] inuse_i,
    input logic [1:0][4:0] rs_addr_i,
    input logic [`DI_XLEN-1:0] rs1_data_i,
    input logic [`DI_XLEN-1:0] rs2_data_i,
    input logic [`DI_NUM_UNITS-1:0] unit_ready_i,
    input logic flush_i,
    input logic issue_hold_i,
    input logic [`DI_NUM_UNITS-1:0] issue_to_i,
    input logic instruction_issued_i,
    input logic [31:0] issue_instr_i,
    input logic [`DI_XLEN-1:0] issue_pc_i,
    input logic [`DI_XLEN-1:0] constant_adder_i,
    input logic [`DI_XLEN:0] alu_in1_i,
    input logic [`DI_XLEN:0] alu_in2_i,
    input logic [4:0] shift_amount_i,
    input rv_decode_pkg::alu_op_t alu_op_i,
    input rv_decode_pkg::alu_logic_op_t alu_logic_op_i,
    input logic alu_subtract_i,
    output logic busy_o,
    output int value_errors_o,
    output int protocol_errors_o
);
    timeunit 1ns;
    timeprecision 100ps;

    import rv_decode_pkg::*;

    typedef struct packed {
        logic [31:0] instr;
        logic [`DI_XLEN-1:0] pc;
    } entry_t;

    typedef struct packed {
        logic [`DI_NUM_UNITS-1:0] units;
        logic uses_rs1;
        logic uses_rs2;
        logic [`DI_XLEN-1:0] const_sum;
        logic [`DI_XLEN:0] in1;
        logic [`DI_XLEN:0] in2;
        logic [4:0] shamt;
        alu_op_t op;
        alu_logic_op_t logic_op;
        logic subtract;
    } expect_t;

    // Instructions advanced into the stage and not yet issued
    entry_t pending[$];
    int issued_count;

    initial begin
        value_errors_o = 0;
        protocol_errors_o = 0;
        issued_count = 0;
        busy_o = 1'b0;
    end

    ////////////////////////////////////////
    // Expected decode of one instruction
    function automatic expect_t reference_result(input logic [31:0] instr,
                                                 input logic [`DI_XLEN-1:0] pc,
                                                 input logic [`DI_XLEN-1:0] rs1_val,
                                                 input logic [`DI_XLEN-1:0] rs2_val);
        expect_t e;
        opcode_t opc;
        logic [2:0] f3;
        logic [31:0] imm_i;
        logic [31:0] upper;
        logic [31:0] op2;
        logic signed_op;
        opc = opcode_t'(instr[6:2]);
        f3 = instr[14:12];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        upper = {instr[31:12], 12'h000};
        e = '0;
        case (opc)
            BRANCH: e.units[`DI_UNIT_BR] = 1'b1;
            JAL, JALR: begin
                e.units[`DI_UNIT_BR] = 1'b1;
                e.units[`DI_UNIT_ALU] = 1'b1;
            end
            LUI, AUIPC, ARITH_IMM: e.units[`DI_UNIT_ALU] = 1'b1;
            // funct7 bit 0 selects the M extension
            ARITH: begin
                if (instr[25]) begin
                    e.units[`DI_UNIT_MULDIV] = 1'b1;
                end else begin
                    e.units[`DI_UNIT_ALU] = 1'b1;
                end
            end
            LOAD, STORE, FENCE: e.units[`DI_UNIT_LS] = 1'b1;
            SYSTEM: e.units[`DI_UNIT_SYS] = 1'b1;
            default: e.units = '0;
        endcase
        e.uses_rs1 = opc inside {JALR, BRANCH, LOAD, STORE, ARITH_IMM, ARITH};
        e.uses_rs2 = opc inside {BRANCH, ARITH};
        if (opc == LUI) begin
            e.const_sum = upper;
        end else if (opc == AUIPC) begin
            e.const_sum = pc + upper;
        end else begin
            e.const_sum = pc + 32'd4;
        end
        if (opc inside {LUI, AUIPC, JAL, JALR}) begin
            e.op = CONSTANT;
        end else if (f3 == 3'b010 || f3 == 3'b011) begin
            e.op = SLT;
        end else if (f3 == 3'b001 || f3 == 3'b101) begin
            e.op = SHIFT;
        end else begin
            e.op = ADD_SUB;
        end
        case (f3)
            3'b100: e.logic_op = XOR;
            3'b110: e.logic_op = OR;
            3'b111: e.logic_op = AND;
            default: e.logic_op = ADD;
        endcase
        e.subtract = (f3 == 3'b010) || (f3 == 3'b011) ||
                     ((opc == ARITH) && (f3 == 3'b000) && instr[30]);
        op2 = (opc == ARITH_IMM) ? imm_i : rs2_val;
        signed_op = !f3[0];
        e.in1 = {rs1_val[31] & signed_op, rs1_val};
        e.in2 = {op2[31] & signed_op, op2};
        e.shamt = (opc == ARITH_IMM) ? instr[24:20] : rs2_val[4:0];
        return e;
    endfunction

    task automatic check_value(input string name, input logic [`DI_XLEN-1:0] pc,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            value_errors_o++;
            $display("FAILED %s at pc %h: expected %h, actual %h", name, pc, expected, actual);
        end
    endtask

    task automatic report_problem(input string msg);
        protocol_errors_o++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic compare_issue(input entry_t head, input expect_t e);
        opcode_t opc;
        logic alu_arith;
        opc = opcode_t'(head.instr[6:2]);
        alu_arith = (opc inside {ARITH, ARITH_IMM}) && e.units[`DI_UNIT_ALU];
        check_value("issue_to", head.pc, 64'(e.units), 64'(issue_to_i));
        check_value("issue_pc", head.pc, 64'(head.pc), 64'(issue_pc_i));
        check_value("issue_instr", head.pc, 64'(head.instr), 64'(issue_instr_i));
        // Source fields of the held word go to the register file
        check_value("rs1_addr", head.pc, 64'(head.instr[19:15]), 64'(rs_addr_i[`DI_RS1]));
        check_value("rs2_addr", head.pc, 64'(head.instr[24:20]), 64'(rs_addr_i[`DI_RS2]));
        if (opc inside {LUI, AUIPC, JAL, JALR, BRANCH}) begin
            check_value("constant_adder", head.pc, 64'(e.const_sum), 64'(constant_adder_i));
        end
        if (e.units[`DI_UNIT_ALU]) begin
            check_value("alu_op", head.pc, 64'(e.op), 64'(alu_op_i));
        end
        if (alu_arith) begin
            check_value("alu_logic_op", head.pc, 64'(e.logic_op), 64'(alu_logic_op_i));
            check_value("alu_subtract", head.pc, 64'(e.subtract), 64'(alu_subtract_i));
            check_value("alu_in1", head.pc, 64'(e.in1), 64'(alu_in1_i));
            check_value("alu_in2", head.pc, 64'(e.in2), 64'(alu_in2_i));
            if (e.op == SHIFT) begin
                check_value("shift_amount", head.pc, 64'(e.shamt), 64'(shift_amount_i));
            end
        end
    endtask

    ////////////////////////////////////////
    // Cycle by cycle comparison, sampled at the rising edge
    always @(posedge clk) begin : compare_proc
        expect_t exp_res;
        entry_t head;
        entry_t incoming;
        logic exp_issue;
        logic exp_advance;
        if (rst) begin
            pending.delete();
        end else begin
            exp_issue = 1'b0;
            exp_res = '0;
            head = '0;
            if (pending.size() != 0) begin
                head = pending[0];
                exp_res = reference_result(head.instr, head.pc, rs1_data_i, rs2_data_i);
                exp_issue = ((exp_res.units & ~unit_ready_i) == '0) && !issue_hold_i &&
                            !flush_i && !(exp_res.uses_rs1 && inuse_i[`DI_RS1]) &&
                            !(exp_res.uses_rs2 && inuse_i[`DI_RS2]);
            end
            exp_advance = decode_valid_i && ((pending.size() == 0) || exp_issue);
            check_value("issue_decision", head.pc, 64'(exp_issue), 64'(instruction_issued_i));
            check_value("decode_advance", decode_pc_i, 64'(exp_advance), 64'(decode_advance_i));
            if (instruction_issued_i) begin
                if (pending.size() == 0) begin
                    report_problem("instruction issued with nothing advanced into the stage");
                end else begin
                    void'(pending.pop_front());
                    compare_issue(head, exp_res);
                    issued_count++;
                end
            end else if (issue_to_i != '0) begin
                report_problem("issue_to_o pulsed without instruction_issued_o");
            end
            if (decode_advance_i) begin
                incoming.instr = decode_instr_i;
                incoming.pc = decode_pc_i;
                pending.push_back(incoming);
            end
            // A flush drops the held one and anything advancing with it
            if (flush_i) begin
                pending.delete();
            end
        end
        busy_o = (pending.size() != 0);
    end

    always @(posedge done_i) begin
        $display("Checked %0d issued instructions: %0d value errors, %0d protocol errors",
                 issued_count, value_errors_o, protocol_errors_o);
    end

endmodule

/* source/decode_issue_top.sv */
`include "decode_issue_cfg.svh"

module decode_issue_top (
    input logic clk,
    input logic rst,
    // Fetch
    input logic decode_valid_i,
    input logic [`DI_XLEN-1:0] decode_pc_i,
    input rv_decode_pkg::instr_u decode_instr_i,
    output logic decode_advance_o,
    // Scoreboard and register file
    input logic [1:0] inuse_i,
    output logic [1:0][4:0] rs_addr_o,
    input logic [`DI_XLEN-1:0] rs1_data_i,
    input logic [`DI_XLEN-1:0] rs2_data_i,
    // Units and control
    input logic [`DI_NUM_UNITS-1:0] unit_ready_i,
    input logic flush_i,
    input logic issue_hold_i,
    output logic [`DI_NUM_UNITS-1:0] issue_to_o,
    output logic instruction_issued_o,
    output rv_decode_pkg::instr_u issue_instr_o,
    output logic [`DI_XLEN-1:0] issue_pc_o,
    // ALU operands
    output logic [`DI_XLEN-1:0] constant_adder_o,
    output logic [`DI_XLEN:0] alu_in1_o,
    output logic [`DI_XLEN:0] alu_in2_o,
    output logic [4:0] shift_amount_o,
    output rv_decode_pkg::alu_op_t alu_op_o,
    output rv_decode_pkg::alu_logic_op_t alu_logic_op_o,
    output logic alu_subtract_o
);

    import rv_decode_pkg::*;

    logic [`DI_NUM_UNITS-1:0] unit_needed;
    logic uses_rs1;
    logic uses_rs2;
    alu_op_t dec_alu_op;
    alu_logic_op_t dec_alu_logic_op;
    logic dec_alu_subtract;
    logic dec_alu_imm_type;
    logic stage_ready;

    ////////////////////////////////////////
    // Decode of the incoming instruction
    // rd use is for the scoreboard side and not needed at issue here
    rv_decoder u_decoder (
        .decode_instr_i (decode_instr_i),
        .unit_needed_o (unit_needed),
        .uses_rs1_o (uses_rs1),
        .uses_rs2_o (uses_rs2),
        .uses_rd_o (),
        .alu_op_o (dec_alu_op),
        .alu_logic_op_o (dec_alu_logic_op),
        .alu_subtract_o (dec_alu_subtract),
        .alu_imm_type_o (dec_alu_imm_type)
    );

    issue_stage u_issue (
        .clk (clk),
        .rst (rst),
        .decode_valid_i (decode_valid_i),
        .decode_pc_i (decode_pc_i),
        .decode_instr_i (decode_instr_i),
        .unit_needed_i (unit_needed),
        .uses_rs1_i (uses_rs1),
        .uses_rs2_i (uses_rs2),
        .inuse_i (inuse_i),
        .unit_ready_i (unit_ready_i),
        .flush_i (flush_i),
        .issue_hold_i (issue_hold_i),
        .decode_advance_o (decode_advance_o),
        .stage_ready_o (stage_ready),
        .issue_instr_o (issue_instr_o),
        .issue_pc_o (issue_pc_o),
        .issue_to_o (issue_to_o),
        .instruction_issued_o (instruction_issued_o),
        .rs_addr_o (rs_addr_o)
    );

    // ALU controls load in step with the issue register
    alu_operand_gen u_alu_ops (
        .clk (clk),
        .decode_load_i (stage_ready),
        .decode_pc_i (decode_pc_i),
        .decode_instr_i (decode_instr_i),
        .alu_op_i (dec_alu_op),
        .alu_logic_op_i (dec_alu_logic_op),
        .alu_subtract_i (dec_alu_subtract),
        .alu_imm_type_i (dec_alu_imm_type),
        .issue_instr_i (issue_instr_o),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .constant_adder_o (constant_adder_o),
        .alu_in1_o (alu_in1_o),
        .alu_in2_o (alu_in2_o),
        .shift_amount_o (shift_amount_o),
        .alu_op_o (alu_op_o),
        .alu_logic_op_o (alu_logic_op_o),
        .alu_subtract_o (alu_subtract_o)
    );

endmodule

/* source/alu_operand_gen.sv */
`include "decode_issue_cfg.svh"

module alu_operand_gen (
    input logic clk,
    input logic decode_load_i,
    input logic [`DI_XLEN-1:0] decode_pc_i,
    input rv_decode_pkg::instr_u decode_instr_i,
    input rv_decode_pkg::alu_op_t alu_op_i,
    input rv_decode_pkg::alu_logic_op_t alu_logic_op_i,
    input logic alu_subtract_i,
    input logic alu_imm_type_i,
    input rv_decode_pkg::instr_u issue_instr_i,
    input logic [`DI_XLEN-1:0] rs1_data_i,
    input logic [`DI_XLEN-1:0] rs2_data_i,
    output logic [`DI_XLEN-1:0] constant_adder_o,
    output logic [`DI_XLEN:0] alu_in1_o,
    output logic [`DI_XLEN:0] alu_in2_o,
    output logic [4:0] shift_amount_o,
    output rv_decode_pkg::alu_op_t alu_op_o,
    output rv_decode_pkg::alu_logic_op_t alu_logic_op_o,
    output logic alu_subtract_o
);

    import rv_decode_pkg::*;

    opcode_t opcode_trim;
    logic [`DI_XLEN-1:0] upper_imm;
    logic alu_imm_type_r;
    logic [`DI_XLEN-1:0] operand2;
    logic unsigned_op;

    assign opcode_trim = opcode_t'(decode_instr_i.i.opcode[6:2]);
    assign upper_imm = {decode_instr_i.i.imm, decode_instr_i.i.rs1,
                        decode_instr_i.i.funct3, 12'b0};

    ////////////////////////////////////////
    // Loaded together with the issue register
    // Constant adder gives LUI, AUIPC and link results, and PC+4 otherwise
    always_ff @(posedge clk) begin
        if (decode_load_i) begin
            constant_adder_o <= ((opcode_trim == LUI) ? '0 : decode_pc_i) +
                ((opcode_trim inside {LUI, AUIPC}) ? upper_imm : `DI_XLEN'd4);
            alu_op_o <= alu_op_i;
            alu_logic_op_o <= alu_logic_op_i;
            alu_subtract_o <= alu_subtract_i;
            alu_imm_type_r <= alu_imm_type_i;
        end
    end

    ////////////////////////////////////////
    // Operands in the issue cycle
    assign operand2 = alu_imm_type_r ?
        {{(`DI_XLEN-12){issue_instr_i.i.imm[11]}}, issue_instr_i.i.imm} : rs2_data_i;

    // funct3 bit 0 marks SLTU and SLTIU, compared without sign
    assign unsigned_op = issue_instr_i.i.funct3[0];

    assign alu_in1_o = {rs1_data_i[`DI_XLEN-1] & !unsigned_op, rs1_data_i};
    assign alu_in2_o = {operand2[`DI_XLEN-1] & !unsigned_op, operand2};

    // shamt sits in the low immediate bits for the immediate shifts
    assign shift_amount_o = alu_imm_type_r ? issue_instr_i.i.imm[4:0] : rs2_data_i[4:0];

endmodule

/* source/issue_stage.sv */
`include "decode_issue_cfg.svh"

module issue_stage (
    input logic clk,
    input logic rst,
    input logic decode_valid_i,
    input logic [`DI_XLEN-1:0] decode_pc_i,
    input rv_decode_pkg::instr_u decode_instr_i,
    input logic [`DI_NUM_UNITS-1:0] unit_needed_i,
    input logic uses_rs1_i,
    input logic uses_rs2_i,
    input logic [1:0] inuse_i,
    input logic [`DI_NUM_UNITS-1:0] unit_ready_i,
    input logic flush_i,
    input logic issue_hold_i,
    output logic decode_advance_o,
    output logic stage_ready_o,
    output rv_decode_pkg::instr_u issue_instr_o,
    output logic [`DI_XLEN-1:0] issue_pc_o,
    output logic [`DI_NUM_UNITS-1:0] issue_to_o,
    output logic instruction_issued_o,
    output logic [1:0][4:0] rs_addr_o
);

    import rv_decode_pkg::*;

    logic stage_valid;
    logic [`DI_NUM_UNITS-1:0] unit_needed_r;
    logic uses_rs1_r;
    logic uses_rs2_r;
    logic rs1_conflict;
    logic rs2_conflict;
    logic operands_ready;
    logic units_ready;
    logic issue_valid;

    ////////////////////////////////////////
    // Stage load
    // Room for a new instruction when empty or when the held one leaves
    assign stage_ready_o = !stage_valid || instruction_issued_o;
    assign decode_advance_o = decode_valid_i && stage_ready_o;

    always_ff @(posedge clk) begin
        if (stage_ready_o) begin
            issue_instr_o <= decode_instr_i;
            issue_pc_o <= decode_pc_i;
            unit_needed_r <= unit_needed_i;
            uses_rs1_r <= uses_rs1_i;
            uses_rs2_r <= uses_rs2_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            stage_valid <= 1'b0;
        end else if (stage_ready_o) begin
            stage_valid <= decode_valid_i;
        end
    end

    // Held source addresses go to the register file and scoreboard
    assign rs_addr_o[`DI_RS1] = issue_instr_o.r.rs1;
    assign rs_addr_o[`DI_RS2] = issue_instr_o.r.rs2;

    ////////////////////////////////////////
    // Issue decision
    assign rs1_conflict = inuse_i[`DI_RS1] && uses_rs1_r;
    assign rs2_conflict = inuse_i[`DI_RS2] && uses_rs2_r;
    assign operands_ready = !rs1_conflict && !rs2_conflict;

    // Jumps wait until both ALU and branch unit can take them
    assign units_ready = ((unit_needed_r & ~unit_ready_i) == '0);

    assign issue_valid = stage_valid && operands_ready && units_ready && !issue_hold_i;
    assign instruction_issued_o = issue_valid && !flush_i;
    assign issue_to_o = {`DI_NUM_UNITS{instruction_issued_o}} & unit_needed_r;

    ////////////////////////////////////////
    // Checks
    assert property (@(posedge clk) disable iff (rst)
        !stage_valid |-> (issue_to_o == '0))
        else $error("issue_stage: issue pulse with empty stage");

    assert property (@(posedge clk) disable iff (rst)
        flush_i |-> (issue_to_o == '0))
        else $error("issue_stage: issue pulse during flush");

endmodule

/* source/rv_decoder.sv */
`include "decode_issue_cfg.svh"

module rv_decoder (
    input rv_decode_pkg::instr_u decode_instr_i,
    output logic [`DI_NUM_UNITS-1:0] unit_needed_o,
    output logic uses_rs1_o,
    output logic uses_rs2_o,
    output logic uses_rd_o,
    output rv_decode_pkg::alu_op_t alu_op_o,
    output rv_decode_pkg::alu_logic_op_t alu_logic_op_o,
    output logic alu_subtract_o,
    output logic alu_imm_type_o
);

    import rv_decode_pkg::*;

    opcode_t opcode_trim;
    logic [2:0] fn3;
    logic [6:0] fn7;
    logic mul_div_op;
    logic sub_instr;

    // Low two opcode bits are always 2'b11 for 32-bit encodings
    assign opcode_trim = opcode_t'(decode_instr_i.r.opcode[6:2]);
    assign fn3 = decode_instr_i.r.funct3;
    assign fn7 = decode_instr_i.r.funct7;

    ////////////////////////////////////////
    // Unit selection
    assign mul_div_op = (opcode_trim == ARITH) && fn7[0];

    assign unit_needed_o[`DI_UNIT_BR] = opcode_trim inside {BRANCH, JAL, JALR};
    // Jumps also need the ALU to write the link address
    assign unit_needed_o[`DI_UNIT_ALU] =
        (opcode_trim inside {ARITH, ARITH_IMM, AUIPC, LUI, JAL, JALR}) && !mul_div_op;
    assign unit_needed_o[`DI_UNIT_LS] = opcode_trim inside {LOAD, STORE, FENCE};
    assign unit_needed_o[`DI_UNIT_SYS] = (opcode_trim == SYSTEM);
    assign unit_needed_o[`DI_UNIT_MULDIV] = mul_div_op;

    ////////////////////////////////////////
    // Register use
    assign uses_rs1_o = opcode_trim inside {JALR, BRANCH, LOAD, STORE, ARITH_IMM, ARITH};
    // Store data is not waited on at issue
    assign uses_rs2_o = opcode_trim inside {BRANCH, ARITH};
    assign uses_rd_o = opcode_trim inside {LUI, AUIPC, JAL, JALR, LOAD, ARITH_IMM, ARITH};

    ////////////////////////////////////////
    // ALU control
    always_comb begin
        case (opcode_trim)
            LUI, AUIPC, JAL, JALR: begin
                alu_op_o = CONSTANT;
            end
            default: begin
                case (fn3)
                    FN3_SLT, FN3_SLTU: alu_op_o = SLT;
                    FN3_SLL, FN3_SRL_SRA: alu_op_o = SHIFT;
                    default: alu_op_o = ADD_SUB;
                endcase
            end
        endcase
    end

    always_comb begin
        case (fn3)
            FN3_XOR: alu_logic_op_o = XOR;
            FN3_OR: alu_logic_op_o = OR;
            FN3_AND: alu_logic_op_o = AND;
            // ADD, SUB, SLT and SLTU all go through the adder
            default: alu_logic_op_o = ADD;
        endcase
    end

    // SUB only exists in the register form
    assign sub_instr = (opcode_trim == ARITH) && (fn3 == FN3_ADD_SUB) && fn7[5];

    // Comparisons are done by subtraction
    assign alu_subtract_o = (fn3 inside {FN3_SLT, FN3_SLTU}) || sub_instr;
    assign alu_imm_type_o = (opcode_trim == ARITH_IMM);

    ////////////////////////////////////////
    // Checks
    always_comb begin
        assert ($countones(unit_needed_o) <= 2)
            else $error("decoder: more than two units selected");
    end

endmodule

/* source/rv_decode_pkg.sv */
package rv_decode_pkg;

    ////////////////////////////////////////
    // Opcodes, bits [6:2] of the RV32I opcode
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        FENCE     = 5'b00011,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_t;

    // funct3 codes of the integer operations
    localparam logic [2:0] FN3_ADD_SUB = 3'b000;
    localparam logic [2:0] FN3_SLL = 3'b001;
    localparam logic [2:0] FN3_SLT = 3'b010;
    localparam logic [2:0] FN3_SLTU = 3'b011;
    localparam logic [2:0] FN3_XOR = 3'b100;
    localparam logic [2:0] FN3_SRL_SRA = 3'b101;
    localparam logic [2:0] FN3_OR = 3'b110;
    localparam logic [2:0] FN3_AND = 3'b111;

    ////////////////////////////////////////
    // ALU control
    typedef enum logic [1:0] {
        CONSTANT = 2'd0,
        SLT      = 2'd1,
        SHIFT    = 2'd2,
        ADD_SUB  = 2'd3
    } alu_op_t;

    // Adder path result selection
    typedef enum logic [1:0] {
        ADD = 2'd0,
        XOR = 2'd1,
        OR  = 2'd2,
        AND = 2'd3
    } alu_logic_op_t;

    ////////////////////////////////////////
    // Instruction word views
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } i_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

endpackage

/* include/decode_issue_cfg.svh */
`ifndef DECODE_ISSUE_CFG_SVH
`define DECODE_ISSUE_CFG_SVH

// Data and PC width
`define DI_XLEN 32

// Execution units and their bit positions in the unit vectors
`define DI_NUM_UNITS 5
`define DI_UNIT_ALU 0
`define DI_UNIT_BR 1
`define DI_UNIT_LS 2
`define DI_UNIT_SYS 3
`define DI_UNIT_MULDIV 4

// Register file read ports
`define DI_RS1 0
`define DI_RS2 1

`endif
